// ==== compile.f ====
common/rv_branch_pkg.sv
hw/branch_decode.sv
hw/branch_queue.sv
exec_branch/exec_branch.sv
hw/branch_unit_top.sv
testbench/tb_clock_gen.sv
testbench/tb_branch_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the branch unit testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f compile.f \
    --top-module tb_branch_unit -o tb_branch_unit
./obj_dir/tb_branch_unit | tee "$LOG"

if grep -qxF '** PASS **' "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== testbench/tb_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_branch_unit;

    localparam int QUEUE_DEPTH = 4;
    localparam int TIMEOUT     = 200;      // Cycles per wait
    localparam logic [4:0] JAL    = rv_branch_pkg::OP_JAL;
    localparam logic [4:0] JALR   = rv_branch_pkg::OP_JALR;
    localparam logic [4:0] BRANCH = rv_branch_pkg::OP_BRANCH;
    localparam logic [4:0] ALU    = 5'h0c;  // Register ALU op, not a branch

    typedef struct {
        rv_branch_pkg::instr_word_t word;
        logic [31:0]                addr;
        logic [31:0]                next;
        logic [31:0]                rs1;
        logic [31:0]                rs2;
        int                         imm;    // Offset encoded into the word
    } row_t;

    typedef struct packed {
        logic        is_mp;
        logic        taken;
        logic        exc;
        logic [3:0]  cause;
        logic [31:0] link;
        logic [31:0] target;   // Redirect pc for a mispredict
    } outcome_t;

    logic                       clk;
    logic                       rst;
    logic                       in_req;
    logic                       in_ack;
    rv_branch_pkg::instr_word_t in_instr;
    logic [31:0]                in_addr;
    logic [31:0]                in_next_addr;
    logic [31:0]                in_rs1_data;
    logic [31:0]                in_rs2_data;
    logic                       result_valid;
    logic                       result_taken;
    logic                       result_exception;
    logic [3:0]                 result_trap_cause;
    logic [31:0]                result_link;
    logic [31:0]                result_target;
    logic                       mispredict;
    logic [31:0]                mispredict_pc;

    row_t        rows[$];
    outcome_t    exp_q[$];
    outcome_t    obs_q[$];
    logic [31:0] pc;
    logic        m_taken;   // Model copy of the last-taken flag
    logic [31:0] m_target;
    int          seed;
    int          errors;
    int          tests_run;
    int          tests_failed;

    tb_clock_gen #(.PERIOD(4.0)) u_clk (.clk(clk));

    branch_unit_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) dut0 (.*);

    always @(posedge clk) begin : collect
        outcome_t o;
        if (result_valid === 1'b1) begin
            o        = '0;
            o.taken  = result_taken;
            o.exc    = result_exception;
            o.cause  = result_trap_cause;
            o.link   = result_link;
            o.target = result_target;
            obs_q.push_back(o);
        end
        if (mispredict === 1'b1) begin
            o        = '0;
            o.is_mp  = 1'b1;
            o.target = mispredict_pc;
            obs_q.push_back(o);
        end
    end

    function automatic rv_branch_pkg::instr_word_t encode_instr(input logic [4:0] op,
                                                                input logic [2:0] f3,
                                                                input int off);
        rv_branch_pkg::instr_word_t w;
        w = '0;
        if (op == JAL) begin
            w.j.imm20    = off[20];
            w.j.imm19_12 = off[19:12];
            w.j.imm11    = off[11];
            w.j.imm10_1  = off[10:1];
            w.j.rd       = 5'd1;
        end else if (op == JALR) begin
            w.i.imm    = off[11:0];
            w.i.rs1    = 5'd5;
            w.i.funct3 = f3;
            w.i.rd     = 5'd1;
        end else begin
            w.b.imm12   = off[12];
            w.b.imm11   = off[11];
            w.b.imm10_5 = off[10:5];
            w.b.imm4_1  = off[4:1];
            w.b.rs2     = 5'd2;
            w.b.rs1     = 5'd1;
            w.b.funct3  = f3;
        end
        w.i.opcode = {op, 2'b11};
        return w;
    endfunction

    // Reference model, one row at a time in program order
    function automatic void predict(input row_t r);
        outcome_t   o;
        logic [4:0] op;
        logic [2:0] f3;
        logic       illegal;
        o       = '0;
        op      = r.word.i.opcode[6:2];
        f3      = r.word.i.funct3;
        illegal = 1'b0;
        pc      = r.next;
        if (m_taken && r.addr != m_target) begin
            o.is_mp  = 1'b1;
            o.target = m_target;
            m_taken  = 1'b0;
            exp_q.push_back(o);
            return;
        end
        case (op)
            JAL: begin
                o.taken  = 1'b1;
                o.target = r.addr + r.imm;
            end
            JALR: begin
                o.taken  = 1'b1;
                o.target = (r.rs1 + r.imm) & ~32'd1;
                illegal  = f3 != 3'd0;
            end
            BRANCH: begin
                o.target = r.addr + r.imm;
                illegal  = f3 == 3'd2 || f3 == 3'd3;
                case (f3)
                    3'd0:    o.taken = r.rs1 == r.rs2;
                    3'd1:    o.taken = r.rs1 != r.rs2;
                    3'd4:    o.taken = $signed(r.rs1) < $signed(r.rs2);
                    3'd5:    o.taken = $signed(r.rs1) >= $signed(r.rs2);
                    3'd6:    o.taken = r.rs1 < r.rs2;
                    3'd7:    o.taken = r.rs1 >= r.rs2;
                    default: o.taken = 1'b0;
                endcase
            end
            default: begin
                m_taken = 1'b0;
                return;
            end
        endcase
        o.exc   = illegal || o.target[1:0] != 2'b00;
        o.cause = illegal ? rv_branch_pkg::EXC_ILLEGAL_INSTR
                          : (o.exc ? rv_branch_pkg::EXC_INSTR_ADDR_MISALIGNED : 4'd0);
        o.link  = r.next;
        exp_q.push_back(o);
        m_taken = o.taken;
        if (o.taken) begin
            m_target = o.target;
            pc       = o.target;   // Next row follows the branch
        end
    endfunction

    function automatic void add_row(input logic [4:0] op, input logic [2:0] f3, input int imm,
                                    input logic [31:0] rs1, input logic [31:0] rs2);
        row_t r;
        r.word = encode_instr(op, f3, imm);
        r.addr = pc;
        r.next = pc + 32'd4;
        r.rs1  = rs1;
        r.rs2  = rs2;
        r.imm  = imm;
        rows.push_back(r);
        predict(r);
    endfunction

    function automatic void add_plain();
        add_row(ALU, 3'd0, 0, $random(seed), $random(seed));
    endfunction

    task automatic abort_run(input string why);
        $display("Run stopped at %0t ns: %s", $time, why);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic wait_in_ack(input logic level);
        int n;
        n = 0;
        @(posedge clk);
        while (in_ack !== level) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run($sformatf("in_ack did not go to %0b", level));
            end
            @(posedge clk);
        end
    endtask

    task automatic drive_row(input row_t r);
        in_instr     <= r.word;
        in_addr      <= r.addr;
        in_next_addr <= r.next;
        in_rs1_data  <= r.rs1;
        in_rs2_data  <= r.rs2;
        in_req       <= 1'b1;
        wait_in_ack(1'b1);
        in_req <= 1'b0;
        wait_in_ack(1'b0);
    endtask

    task automatic run_test(input string name);
        int n;
        int fails;
        n     = 0;
        fails = 0;
        obs_q.delete();
        foreach (rows[i]) begin
            drive_row(rows[i]);
        end
        while (obs_q.size() < exp_q.size()) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run($sformatf("test %s is missing results from the DUT", name));
            end
            @(posedge clk);
        end
        repeat (12) @(posedge clk);   // Catch stray pulses
        assert (obs_q.size() == exp_q.size()) else begin
            $display("[FAIL] %0t ns %s: %0d events, expected %0d", $time, name,
                     obs_q.size(), exp_q.size());
            fails++;
        end
        for (int i = 0; i < exp_q.size() && i < obs_q.size(); i++) begin
            assert (obs_q[i] == exp_q[i]) else begin
                $display("[FAIL] %0t ns %s: event %0d is %h, expected %h", $time, name, i,
                         obs_q[i], exp_q[i]);
                fails++;
            end
        end
        tests_run++;
        if (fails != 0) begin
            tests_failed++;
        end
        errors += fails;
        $display("test %-11s %2d rows %2d events  %s", name, rows.size(), exp_q.size(),
                 fails == 0 ? "ok" : "failed");
        rows.delete();
        exp_q.delete();
    endtask

    initial begin
        int          sel;
        int          imm;
        logic [31:0] r1;
        logic [2:0]  f3;
        seed         = 32'h4fd7_9c60;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        m_taken      = 1'b0;
        m_target     = '0;
        pc           = 32'h0000_1000;
        rst          <= 1'b1;
        in_req       <= 1'b0;
        in_instr     <= '0;
        in_addr      <= '0;
        in_next_addr <= '0;
        in_rs1_data  <= '0;
        in_rs2_data  <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        add_row(BRANCH, 3'd0, 16, 32'd7, 32'd7);
        add_row(BRANCH, 3'd0, 16, 32'd7, 32'd8);
        add_row(BRANCH, 3'd1, -32, 32'd5, 32'd6);
        add_row(BRANCH, 3'd1, -32, 32'd5, 32'd5);
        add_row(BRANCH, 3'd4, 64, 32'hffff_fffd, 32'd2);   // -3 < 2
        add_row(BRANCH, 3'd4, 64, 32'd2, 32'hffff_fffd);
        add_row(BRANCH, 3'd5, -8, 32'hffff_fffd, 32'hffff_fffd);
        add_row(BRANCH, 3'd5, -8, 32'hffff_fffb, 32'd1);
        add_row(BRANCH, 3'd6, 4092, 32'd2, 32'hffff_fffd);
        add_row(BRANCH, 3'd6, 4092, 32'hffff_fffd, 32'd2);
        add_row(BRANCH, 3'd7, -4096, 32'hffff_fffd, 32'd2);
        add_row(BRANCH, 3'd7, -4096, 32'd2, 32'hffff_fffd);
        run_test("cond");

        add_row(JAL, 3'd0, 2048, $random(seed), $random(seed));
        add_row(JAL, 3'd0, -1024, $random(seed), $random(seed));
        add_row(JALR, 3'd0, 16, 32'h0000_2000, $random(seed));
        add_row(JALR, 3'd0, 5, 32'h0000_3000, $random(seed));   // Bit 0 dropped
        add_row(JALR, 3'd0, -16, 32'h0000_4000, $random(seed));
        add_plain();
        run_test("jumps");

        add_row(JALR, 3'd1, 0, 32'h0000_5000, $random(seed));
        add_row(BRANCH, 3'd2, 8, 32'd1, 32'd1);
        add_row(BRANCH, 3'd3, 6, 32'd1, 32'd2);               // Illegal and misaligned at once
        add_row(BRANCH, 3'd0, 6, 32'd9, 32'd9);               // Target bit 1 set
        add_row(JALR, 3'd0, 2, 32'h0000_6000, $random(seed));
        add_row(JAL, 3'd0, 10, $random(seed), $random(seed));
        add_plain();
        run_test("exceptions");

        pc = 32'h0000_2000;
        add_row(BRANCH, 3'd0, 32, 32'd1, 32'd1);
        pc = pc + 32'd8;                                     // Wrong path
        add_plain();
        add_row(BRANCH, 3'd1, 100, 32'd1, 32'd2);
        add_row(BRANCH, 3'd0, 100, 32'd1, 32'd2);
        add_row(JAL, 3'd0, 256, $random(seed), $random(seed));
        pc = pc + 32'd8;
        add_row(JALR, 3'd0, 0, 32'h0000_0040, $random(seed));
        add_plain();
        run_test("mispredict");

        add_row(JAL, 3'd0, 64, $random(seed), $random(seed));
        add_plain();
        pc = 32'h0000_7000;                                  // Jump away after a plain op
        add_plain();
        add_row(BRANCH, 3'd0, 12, 32'd3, 32'd4);
        add_plain();
        run_test("non_branch");

        for (int k = 0; k < 3 * QUEUE_DEPTH; k++) begin
            sel = $unsigned($random(seed)) % 6;
            f3  = sel < 2 ? 3'(sel) : 3'(sel + 2);
            imm = (($unsigned($random(seed)) % 64) - 32) * 4;
            r1  = $random(seed);
            add_row(BRANCH, f3, imm, r1, (k % 3 == 0) ? r1 : $random(seed));
        end
        add_plain();
        run_test("burst");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== hw/branch_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              in_req,
    output logic                             in_ack,
    input  rv_branch_pkg::instr_word_t       in_instr,
    input  wire [rv_branch_pkg::ALEN-1:0]    in_addr,
    input  wire [rv_branch_pkg::ALEN-1:0]    in_next_addr,
    input  wire [rv_branch_pkg::XLEN-1:0]    in_rs1_data,
    input  wire [rv_branch_pkg::XLEN-1:0]    in_rs2_data,
    output logic                             result_valid,
    output logic                             result_taken,
    output logic                             result_exception,
    output logic [3:0]                       result_trap_cause,
    output logic [rv_branch_pkg::XLEN-1:0]   result_link,
    output logic [rv_branch_pkg::ALEN-1:0]   result_target,
    output logic                             mispredict,
    output logic [rv_branch_pkg::ALEN-1:0]   mispredict_pc
);

    // Decode to queue
    logic                            dq_req;
    logic                            dq_ack;
    logic [rv_branch_pkg::ALEN-1:0]  dq_addr;
    logic [rv_branch_pkg::ALEN-1:0]  dq_next_addr;
    logic [4:0]                      dq_opcode;
    logic [2:0]                      dq_funct3;
    logic [11:0]                     dq_i_imm;
    logic [11:0]                     dq_b_imm;
    logic [19:0]                     dq_j_imm;
    logic [rv_branch_pkg::XLEN-1:0]  dq_rs1_data;
    logic [rv_branch_pkg::XLEN-1:0]  dq_rs2_data;
    logic                            dq_is_branch;

    // Queue to execution
    logic                            qe_req;
    logic                            qe_ack;
    logic [rv_branch_pkg::ALEN-1:0]  qe_addr;
    logic [rv_branch_pkg::ALEN-1:0]  qe_next_addr;
    logic [4:0]                      qe_opcode;
    logic [2:0]                      qe_funct3;
    logic [11:0]                     qe_i_imm;
    logic [11:0]                     qe_b_imm;
    logic [19:0]                     qe_j_imm;
    logic [rv_branch_pkg::XLEN-1:0]  qe_rs1_data;
    logic [rv_branch_pkg::XLEN-1:0]  qe_rs2_data;
    logic                            qe_is_branch;

    branch_decode u_decode (.*);

    branch_queue #(
        .DEPTH(QUEUE_DEPTH)
    ) u_queue (.*);

    exec_branch u_exec (.*);

endmodule

`default_nettype wire

// ==== exec_branch/exec_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_branch (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              qe_req,
    output logic                             qe_ack,
    input  wire [rv_branch_pkg::ALEN-1:0]    qe_addr,
    input  wire [rv_branch_pkg::ALEN-1:0]    qe_next_addr,
    input  wire [4:0]                        qe_opcode,
    input  wire [2:0]                        qe_funct3,
    input  wire [11:0]                       qe_i_imm,
    input  wire [11:0]                       qe_b_imm,
    input  wire [19:0]                       qe_j_imm,
    input  wire [rv_branch_pkg::XLEN-1:0]    qe_rs1_data,
    input  wire [rv_branch_pkg::XLEN-1:0]    qe_rs2_data,
    input  wire                              qe_is_branch,
    output logic                             result_valid,
    output logic                             result_taken,
    output logic                             result_exception,
    output logic [3:0]                       result_trap_cause,
    output logic [rv_branch_pkg::XLEN-1:0]   result_link,
    output logic [rv_branch_pkg::ALEN-1:0]   result_target,
    output logic                             mispredict,
    output logic [rv_branch_pkg::ALEN-1:0]   mispredict_pc
);

    localparam int AL = rv_branch_pkg::ALEN;

    logic          is_jal;
    logic          is_jalr;
    logic          is_cond;
    logic [AL-1:0] add_a;
    logic [AL-1:0] add_b;
    logic [AL-1:0] add_sum;
    logic [AL-1:0] target;
    logic          rs_eq;
    logic          rs_lt;
    logic          rs_ltu;
    logic          taken;
    logic          illegal;
    logic          exception;
    logic [3:0]    cause;
    logic          accept;
    logic          mismatch;
    logic          last_taken;
    logic [AL-1:0] last_target;

    assign is_jal  = qe_opcode == rv_branch_pkg::OP_JAL;
    assign is_jalr = qe_opcode == rv_branch_pkg::OP_JALR;
    assign is_cond = qe_opcode == rv_branch_pkg::OP_BRANCH;

    // Single target adder, operands picked per opcode
    always_comb begin
        add_a = qe_addr;
        add_b = '0;
        if (is_jal) begin
            add_b = {{(AL - 21){qe_j_imm[19]}}, qe_j_imm, 1'b0};
        end else if (is_jalr) begin
            add_a = qe_rs1_data;
            add_b = {{(AL - 12){qe_i_imm[11]}}, qe_i_imm};
        end else if (is_cond) begin
            add_b = {{(AL - 13){qe_b_imm[11]}}, qe_b_imm, 1'b0};
        end
    end

    assign add_sum = add_a + add_b;
    assign target  = is_jalr ? {add_sum[AL-1:1], 1'b0} : add_sum;

    assign rs_eq  = qe_rs1_data == qe_rs2_data;
    assign rs_ltu = qe_rs1_data < qe_rs2_data;
    assign rs_lt  = $signed(qe_rs1_data) < $signed(qe_rs2_data);

    always_comb begin
        taken   = is_jal || is_jalr;
        illegal = is_jalr && qe_funct3 != 3'b000;
        if (is_cond) begin
            case (qe_funct3)
                3'b000:  taken = rs_eq;     // BEQ
                3'b001:  taken = !rs_eq;    // BNE
                3'b100:  taken = rs_lt;     // BLT
                3'b101:  taken = !rs_lt;    // BGE
                3'b110:  taken = rs_ltu;    // BLTU
                3'b111:  taken = !rs_ltu;   // BGEU
                default: illegal = 1'b1;    // 010, 011 undefined
            endcase
        end
    end

    // Illegal outranks misaligned
    assign exception = illegal || target[1] || target[0];
    assign cause     = illegal ? rv_branch_pkg::EXC_ILLEGAL_INSTR
                               : rv_branch_pkg::EXC_INSTR_ADDR_MISALIGNED;

    assign accept   = qe_req && !qe_ack;
    assign mismatch = last_taken && last_target != qe_addr;

    always_ff @(posedge clk) begin
        if (accept && !mismatch && qe_is_branch) begin
            result_taken      <= taken;
            result_exception  <= exception;
            result_trap_cause <= exception ? cause : 4'd0;
            result_link       <= qe_next_addr;   // Value JAL/JALR write to rd
            result_target     <= target;
        end
        if (accept && mismatch) begin
            mispredict_pc <= last_target;
        end
        if (accept && !mismatch && qe_is_branch && taken) begin
            last_target <= target;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            qe_ack       <= 1'b0;
            result_valid <= 1'b0;
            mispredict   <= 1'b0;
            last_taken   <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            mispredict   <= 1'b0;
            if (accept) begin
                qe_ack <= 1'b1;
                if (mismatch) begin
                    mispredict <= 1'b1;   // Item squashed
                    last_taken <= 1'b0;
                end else begin
                    result_valid <= qe_is_branch;
                    last_taken   <= qe_is_branch && taken;
                end
            end else if (qe_ack && !qe_req) begin
                qe_ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/branch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_queue #(
    parameter int DEPTH = 4
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              dq_req,
    output logic                             dq_ack,
    input  wire [rv_branch_pkg::ALEN-1:0]    dq_addr,
    input  wire [rv_branch_pkg::ALEN-1:0]    dq_next_addr,
    input  wire [4:0]                        dq_opcode,
    input  wire [2:0]                        dq_funct3,
    input  wire [11:0]                       dq_i_imm,
    input  wire [11:0]                       dq_b_imm,
    input  wire [19:0]                       dq_j_imm,
    input  wire [rv_branch_pkg::XLEN-1:0]    dq_rs1_data,
    input  wire [rv_branch_pkg::XLEN-1:0]    dq_rs2_data,
    input  wire                              dq_is_branch,
    output logic                             qe_req,
    input  wire                              qe_ack,
    output logic [rv_branch_pkg::ALEN-1:0]   qe_addr,
    output logic [rv_branch_pkg::ALEN-1:0]   qe_next_addr,
    output logic [4:0]                       qe_opcode,
    output logic [2:0]                       qe_funct3,
    output logic [11:0]                      qe_i_imm,
    output logic [11:0]                      qe_b_imm,
    output logic [19:0]                      qe_j_imm,
    output logic [rv_branch_pkg::XLEN-1:0]   qe_rs1_data,
    output logic [rv_branch_pkg::XLEN-1:0]   qe_rs2_data,
    output logic                             qe_is_branch
);

    localparam int AW = $clog2(DEPTH);
    localparam int W  = 2 * rv_branch_pkg::ALEN + 5 + 3 + 12 + 12 + 20
                      + 2 * rv_branch_pkg::XLEN + 1;

    logic [W-1:0]  mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign push = dq_req && !dq_ack && count != (AW + 1)'(DEPTH);
    assign pop  = qe_req && qe_ack;   // Ack just rose

    assign {qe_addr, qe_next_addr, qe_opcode, qe_funct3, qe_i_imm, qe_b_imm, qe_j_imm,
            qe_rs1_data, qe_rs2_data, qe_is_branch} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {dq_addr, dq_next_addr, dq_opcode, dq_funct3, dq_i_imm, dq_b_imm,
                            dq_j_imm, dq_rs1_data, dq_rs2_data, dq_is_branch};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            dq_ack <= 1'b0;
            qe_req <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
                dq_ack <= 1'b1;
            end else if (dq_ack && !dq_req) begin
                dq_ack <= 1'b0;
            end

            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                qe_req <= 1'b0;
            end else if (!qe_req && !qe_ack && count != '0) begin
                qe_req <= 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/branch_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_decode (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              in_req,
    output logic                             in_ack,
    input  rv_branch_pkg::instr_word_t       in_instr,
    input  wire [rv_branch_pkg::ALEN-1:0]    in_addr,
    input  wire [rv_branch_pkg::ALEN-1:0]    in_next_addr,
    input  wire [rv_branch_pkg::XLEN-1:0]    in_rs1_data,
    input  wire [rv_branch_pkg::XLEN-1:0]    in_rs2_data,
    output logic                             dq_req,
    input  wire                              dq_ack,
    output logic [rv_branch_pkg::ALEN-1:0]   dq_addr,
    output logic [rv_branch_pkg::ALEN-1:0]   dq_next_addr,
    output logic [4:0]                       dq_opcode,
    output logic [2:0]                       dq_funct3,
    output logic [11:0]                      dq_i_imm,
    output logic [11:0]                      dq_b_imm,
    output logic [19:0]                      dq_j_imm,
    output logic [rv_branch_pkg::XLEN-1:0]   dq_rs1_data,
    output logic [rv_branch_pkg::XLEN-1:0]   dq_rs2_data,
    output logic                             dq_is_branch
);

    logic       full;   // Decoded item held
    logic       sent;   // Downstream acked, waiting for ack to fall
    logic       take;
    logic [4:0] opcode;

    assign take   = in_req && !in_ack && !full;
    assign opcode = in_instr.i.opcode[6:2];

    always_ff @(posedge clk) begin
        if (take) begin
            dq_addr      <= in_addr;
            dq_next_addr <= in_next_addr;
            dq_opcode    <= opcode;
            dq_funct3    <= in_instr.i.funct3;
            dq_i_imm     <= in_instr.i.imm;
            dq_b_imm     <= {in_instr.b.imm12, in_instr.b.imm11,
                             in_instr.b.imm10_5, in_instr.b.imm4_1};
            dq_j_imm     <= {in_instr.j.imm20, in_instr.j.imm19_12,
                             in_instr.j.imm11, in_instr.j.imm10_1};
            dq_rs1_data  <= in_rs1_data;
            dq_rs2_data  <= in_rs2_data;
            dq_is_branch <= opcode == rv_branch_pkg::OP_JAL
                         || opcode == rv_branch_pkg::OP_JALR
                         || opcode == rv_branch_pkg::OP_BRANCH;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ack <= 1'b0;
            dq_req <= 1'b0;
            full   <= 1'b0;
            sent   <= 1'b0;
        end else begin
            if (take) begin
                in_ack <= 1'b1;
                full   <= 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end

            if (full && !sent && !dq_req && !dq_ack) begin
                dq_req <= 1'b1;   // One cycle after capture
            end else if (dq_req && dq_ack) begin
                dq_req <= 1'b0;
                sent   <= 1'b1;
            end else if (sent && !dq_ack) begin
                full <= 1'b0;     // Free for the next item
                sent <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== common/rv_branch_pkg.sv ====
`default_nettype none

package rv_branch_pkg;

    parameter int XLEN = 32;
    parameter int ALEN = 32;

    // Major opcodes, instruction bits 6:2
    parameter logic [4:0] OP_JAL    = 5'h1b;
    parameter logic [4:0] OP_JALR   = 5'h19;
    parameter logic [4:0] OP_BRANCH = 5'h18;

    parameter logic [3:0] EXC_INSTR_ADDR_MISALIGNED = 4'd0;
    parameter logic [3:0] EXC_ILLEGAL_INSTR         = 4'd2;

    // One instruction word, three immediate layouts
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic        imm12;
            logic [5:0]  imm10_5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [3:0]  imm4_1;
            logic        imm11;
            logic [6:0]  opcode;
        } b;
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j;
    } instr_word_t;

endpackage

`default_nettype wire
